/* list.f */
src/ppu_pkg.sv
src/ppu_regs.sv
src/ppu_scroll_addr.sv
src/ppu_data_port.sv
src/ppu_frame_timing.sv
src/ppu_top.sv
bench/tb_ppu.sv

/* run.sh */
#!/bin/sh
# Build the PPU testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

rm -f "$LOG"

verilator --binary --timing --timescale 1ns/1ns \
	-f list.f --top-module tb_ppu -Mdir "$OBJ" -o sim_ppu
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ/sim_ppu" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation binary returned status $status"
	exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
	exit 0
fi

echo "Pass line not found in $LOG"
exit 1

/* bench/tb_ppu.sv */
/*
 * PPU core testbench
 * Random CPU accesses checked against a register model and a VRAM memory model
 */

module tb_ppu;

	timeunit 1ns;
	timeprecision 1ns;

	// Frame geometry of 341 dots by 262 lines
	localparam int DOTS  = 341;
	localparam int FRAME = DOTS * 262;
	// Flag follows the edge that leaves dot 1 and shows one position later
	localparam int VS = 241 * DOTS + 2;
	localparam int VE = 261 * DOTS + 2;

	logic               CLK;
	logic               RESET;
	ppu_pkg::cpu_bus_t  cpu;
	logic [7:0]         cpu_rdata;
	logic               nmi;
	ppu_pkg::vram_req_t vram;
	logic [7:0]         vram_rdata;

	// VRAM model that answers one cycle after rd
	logic [7:0]  vram_mem [0:16383];
	logic        rd_seen;
	logic [7:0]  rd_data;

	// Reference model state
	logic        m_nmi_en;
	logic        m_inc;
	logic        m_toggle;
	logic [14:0] m_t;
	logic [14:0] m_v;
	logic [7:0]  m_buf;
	logic [7:0]  m_rdata;
	// Frame in which a status read cleared the flag
	int          m_clr_frame;

	int          cycle;
	int          checks;
	int          errors;
	int          timeouts;
	logic [31:0] seed;

	ppu_top dut0 (
		.CLK        (CLK),
		.RESET      (RESET),
		.cpu        (cpu),
		.cpu_rdata  (cpu_rdata),
		.nmi        (nmi),
		.vram       (vram),
		.vram_rdata (vram_rdata)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	// Edges since reset release give the frame position before wrap
	always @(posedge CLK) begin
		if (RESET) begin
			cycle <= 0;
		end else begin
			cycle <= cycle + 1;
		end
	end

	// Memory samples the bus where it is stable and answers on the next cycle
	always @(posedge CLK) begin
		#10;
		if (rd_seen) begin
			vram_rdata = rd_data;
		end
		rd_seen = vram.rd;
		if (vram.rd) begin
			rd_data = vram_mem[vram.addr];
		end
		if (vram.wr) begin
			vram_mem[vram.addr] = vram.wdata;
		end
	end

	// ========================================================================
	// Helpers
	// ========================================================================

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		seed = xorshift(seed);
		return seed;
	endfunction

	function automatic logic in_window(input int n);
		return ((n % FRAME) >= VS) && ((n % FRAME) < VE);
	endfunction

	// Vblank flag after edge n
	function automatic logic flag_at(input int n);
		return in_window(n) && ((n / FRAME) != m_clr_frame);
	endfunction

	// Keeps checks clear of the fixed flag edges
	function automatic logic near_edge(input int n);
		int pos;
		pos = n % FRAME;
		return ((pos >= VS - 4) && (pos <= VS + 4)) ||
			((pos >= VE - 4) && (pos <= VE + 4));
	endfunction

	function automatic logic [2:0] ignored_offset(input logic [1:0] sel);
		case (sel)
			2'd0: return ppu_pkg::REG_MASK;
			2'd1: return ppu_pkg::REG_OAMADDR;
			default: return ppu_pkg::REG_OAMDATA;
		endcase
	endfunction

	// Offsets whose reads give zero or leave cpu_rdata alone
	function automatic logic [2:0] other_offset(input logic [2:0] sel);
		case (sel)
			3'd2: return ppu_pkg::REG_OAMADDR;
			3'd3: return ppu_pkg::REG_OAMDATA;
			3'd4: return ppu_pkg::REG_SCROLL;
			3'd5: return ppu_pkg::REG_ADDR;
			3'd6: return ppu_pkg::REG_CTRL;
			default: return ppu_pkg::REG_MASK;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic next_cycle();
		@(posedge CLK);
		#10;
	endtask

	task automatic idle_until(input int target);
		int i;
		for (i = 0; i < 8 && cycle < target; i++) begin
			next_cycle();
			// Requests last only for the cycle right after the access
			check_value("vram.wr", 32'(vram.wr), 32'h0);
			check_value("vram.rd", 32'(vram.rd), 32'h0);
		end
		if (cycle < target) begin
			timeouts++;
			$display("Idle wait did not reach cycle %0d", target);
		end
	endtask

	// Strobe is due in the cycle after the access edge
	task automatic wait_vram(input logic want_wr, output logic seen);
		int i;
		seen = 1'b0;
		for (i = 0; i < 4 && !seen; i++) begin
			if (want_wr ? vram.wr : vram.rd) begin
				seen = 1'b1;
			end else begin
				next_cycle();
			end
		end
		if (!seen) begin
			timeouts++;
			$display("No VRAM %s strobe within 4 cycles", want_wr ? "write" : "read");
		end
	endtask

	// ========================================================================
	// One CPU access with model update and checks over four cycles
	// ========================================================================

	task automatic cpu_access(input logic is_wr, input logic [2:0] offset,
		input logic [7:0] data);
		int          n_a;
		logic        seen;
		logic [14:0] step;
		step = m_inc ? 15'd32 : 15'd1;
		cpu.wr    = is_wr;
		cpu.rd    = !is_wr;
		cpu.addr  = offset;
		cpu.wdata = data;
		next_cycle();
		cpu = '0;
		n_a = cycle;
		// Only a PPUDATA access raises a VRAM strobe
		check_value("vram.wr", 32'(vram.wr), 32'(is_wr && offset == ppu_pkg::REG_DATA));
		check_value("vram.rd", 32'(vram.rd), 32'(!is_wr && offset == ppu_pkg::REG_DATA));
		if (is_wr) begin
			case (offset)
				ppu_pkg::REG_CTRL: begin
					m_nmi_en   = data[7];
					m_inc      = data[2];
					m_t[11:10] = data[1:0];
				end
				ppu_pkg::REG_SCROLL: begin
					if (!m_toggle) begin
						m_t[4:0] = data[7:3];
					end else begin
						m_t[9:5]   = data[7:3];
						m_t[14:12] = data[2:0];
					end
					m_toggle = !m_toggle;
				end
				ppu_pkg::REG_ADDR: begin
					if (!m_toggle) begin
						m_t[13:8] = data[5:0];
						m_t[14]   = 1'b0;
					end else begin
						m_t[7:0] = data;
						m_v      = m_t;
					end
					m_toggle = !m_toggle;
				end
				ppu_pkg::REG_DATA: begin
					wait_vram(1'b1, seen);
					if (seen) begin
						check_value("vram.addr", 32'(vram.addr), 32'(m_v[13:0]));
						check_value("vram.wdata", 32'(vram.wdata), 32'(data));
					end
					m_v = m_v + step;
				end
				default: begin
				end
			endcase
		end else begin
			case (offset)
				ppu_pkg::REG_STATUS: begin
					m_rdata  = {flag_at(n_a - 1), 2'b00, m_rdata[4:0]};
					m_toggle = 1'b0;
					if (in_window(n_a)) begin
						m_clr_frame = n_a / FRAME;
					end
				end
				ppu_pkg::REG_DATA: begin
					wait_vram(1'b0, seen);
					if (seen) begin
						check_value("vram.addr", 32'(vram.addr), 32'(m_v[13:0]));
					end
					// Old buffer goes out and the addressed byte comes in
					m_rdata = m_buf;
					m_buf   = vram_mem[m_v[13:0]];
					m_v     = m_v + step;
				end
				ppu_pkg::REG_CTRL, ppu_pkg::REG_MASK: m_rdata = 8'h00;
				default: begin
				end
			endcase
		end
		check_value("cpu_rdata", 32'(cpu_rdata), 32'(m_rdata));
		idle_until(n_a + 3);
		if (!near_edge(cycle)) begin
			check_value("nmi", 32'(nmi), 32'(m_nmi_en & flag_at(cycle)));
		end
	endtask

	// ========================================================================
	// Stimulus
	// ========================================================================

	initial begin
		logic [31:0] r;
		logic [31:0] base;
		int          i;
		RESET       = 1'b1;
		cpu         = '0;
		vram_rdata  = 8'h00;
		rd_seen     = 1'b0;
		rd_data     = 8'h00;
		seed        = 32'hea6b6f69;
		checks      = 0;
		errors      = 0;
		timeouts    = 0;
		m_nmi_en    = 1'b0;
		m_inc       = 1'b0;
		m_toggle    = 1'b0;
		m_t         = '0;
		m_v         = '0;
		m_buf       = 8'h00;
		m_rdata     = 8'h00;
		m_clr_frame = -1;
		// Fill mixes both address bytes
		for (i = 0; i < 16384; i++) begin
			vram_mem[i] = 8'(i) ^ 8'((i >> 8) * 13);
		end
		repeat (4) @(posedge CLK);
		#10;
		RESET = 1'b0;
		check_value("cpu_rdata", 32'(cpu_rdata), 32'h0);
		check_value("nmi", 32'(nmi), 32'h0);
		check_value("vram.wr", 32'(vram.wr), 32'h0);
		check_value("vram.rd", 32'(vram.rd), 32'h0);

		// Burst of writes from one address pair and buffered reads back from it
		base = next_random();
		cpu_access(1'b1, ppu_pkg::REG_ADDR, base[15:8]);
		cpu_access(1'b1, ppu_pkg::REG_ADDR, base[23:16]);
		for (i = 0; i < 8; i++) begin
			r = next_random();
			cpu_access(1'b1, ppu_pkg::REG_DATA, r[7:0]);
		end
		cpu_access(1'b1, ppu_pkg::REG_ADDR, base[15:8]);
		cpu_access(1'b1, ppu_pkg::REG_ADDR, base[23:16]);
		for (i = 0; i < 9; i++) begin
			cpu_access(1'b0, ppu_pkg::REG_DATA, 8'h00);
		end

		// Random mix over just over two frames
		while (cycle < 2 * FRAME + 1200) begin
			r = next_random();
			case (r[3:0])
				4'd0, 4'd1: cpu_access(1'b1, ppu_pkg::REG_CTRL, r[15:8]);
				4'd2: cpu_access(1'b1, ignored_offset(r[17:16]), r[15:8]);
				4'd3, 4'd4: cpu_access(1'b1, ppu_pkg::REG_SCROLL, r[15:8]);
				4'd5, 4'd6, 4'd7: cpu_access(1'b1, ppu_pkg::REG_ADDR, r[15:8]);
				4'd8, 4'd9, 4'd10: cpu_access(1'b1, ppu_pkg::REG_DATA, r[15:8]);
				4'd11, 4'd12: cpu_access(1'b0, ppu_pkg::REG_DATA, 8'h00);
				4'd13, 4'd14: begin
					if (!near_edge(cycle + 1)) begin
						cpu_access(1'b0, ppu_pkg::REG_STATUS, 8'h00);
					end else begin
						next_cycle();
					end
				end
				default: cpu_access(1'b0, other_offset(r[18:16]), 8'h00);
			endcase
		end

		$display("Checks %0d, value errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* src/ppu_top.sv */
/*
 * PPU CPU-facing core
 * Register window, scroll and address logic, PPUDATA port and frame timing
 */

module ppu_top (
	input  logic               CLK,
	input  logic               RESET,
	input  ppu_pkg::cpu_bus_t  cpu,
	output logic [7:0]         cpu_rdata,
	output logic               nmi,
	output ppu_pkg::vram_req_t vram,
	input  logic [7:0]         vram_rdata
);

	// Decoded register pulses
	logic ctrl_wr;
	logic scroll_wr;
	logic addr_wr;
	logic data_wr;
	logic data_rd;
	logic status_rd;
	logic [7:0] wdata;

	ppu_pkg::ppu_ctrl_t  ctrl;
	ppu_pkg::vram_addr_u vram_addr;
	logic [7:0]          read_buffer;
	logic                vblank;

	// ========================================================================
	// CPU register window
	// ========================================================================

	ppu_regs u_regs (
		.CLK         (CLK),
		.RESET       (RESET),
		.cpu         (cpu),
		.vblank      (vblank),
		.read_buffer (read_buffer),
		.ctrl        (ctrl),
		.ctrl_wr     (ctrl_wr),
		.scroll_wr   (scroll_wr),
		.addr_wr     (addr_wr),
		.data_wr     (data_wr),
		.data_rd     (data_rd),
		.status_rd   (status_rd),
		.wdata       (wdata),
		.cpu_rdata   (cpu_rdata)
	);

	// Toggle plus t and v registers
	ppu_scroll_addr u_scroll_addr (
		.CLK       (CLK),
		.RESET     (RESET),
		.ctrl      (ctrl),
		.ctrl_wr   (ctrl_wr),
		.scroll_wr (scroll_wr),
		.addr_wr   (addr_wr),
		.data_wr   (data_wr),
		.data_rd   (data_rd),
		.status_rd (status_rd),
		.wdata     (wdata),
		.vram_addr (vram_addr)
	);

	// ========================================================================
	// VRAM side and timing
	// ========================================================================

	ppu_data_port u_data_port (
		.CLK         (CLK),
		.RESET       (RESET),
		.data_wr     (data_wr),
		.data_rd     (data_rd),
		.wdata       (wdata),
		.vram_addr   (vram_addr),
		.vram_rdata  (vram_rdata),
		.vram        (vram),
		.read_buffer (read_buffer)
	);

	ppu_frame_timing u_frame_timing (
		.CLK        (CLK),
		.RESET      (RESET),
		.nmi_enable (ctrl.nmi_enable),
		.status_rd  (status_rd),
		.vblank     (vblank),
		.nmi        (nmi)
	);

endmodule

/* src/ppu_frame_timing.sv */
/*
 * PPU frame timing
 * 341 dot by 262 line counter with the vblank flag and the NMI level
 */

module ppu_frame_timing (
	input  logic CLK,
	input  logic RESET,
	input  logic nmi_enable,
	input  logic status_rd,
	output logic vblank,
	output logic nmi
);

	logic [ppu_pkg::DOT_W-1:0]  dot;
	logic [ppu_pkg::LINE_W-1:0] line;
	// Last dot of a line and last line of a frame
	logic end_of_line;
	logic end_of_frame;
	// Fixed flag edges
	logic vblank_set;
	logic vblank_clr;

	assign end_of_line  = (dot == ppu_pkg::CYCLES_PER_LINE - 9'd1);
	assign end_of_frame = (line == ppu_pkg::LINES_PER_FRAME - 9'd1);

	assign vblank_set = (dot == ppu_pkg::VBLANK_DOT) && (line == ppu_pkg::VBLANK_LINE);
	assign vblank_clr = (dot == ppu_pkg::VBLANK_DOT) && (line == ppu_pkg::PRERENDER_LINE);

	// ========================================================================
	// Dot and scanline counter
	// ========================================================================

	always_ff @(posedge CLK) begin
		if (RESET) begin
			dot  <= '0;
			line <= '0;
		end else if (end_of_line) begin
			dot <= '0;
			// Wrap to line 0 after the pre-render line
			line <= end_of_frame ? '0 : line + 9'd1;
		end else begin
			dot <= dot + 9'd1;
		end
	end

	// ========================================================================
	// Vblank flag and NMI
	// ========================================================================

	// Setting the flag wins over a status read on the same edge
	always_ff @(posedge CLK) begin
		if (RESET) begin
			vblank <= 1'b0;
		end else if (vblank_set) begin
			vblank <= 1'b1;
		end else if (vblank_clr || status_rd) begin
			vblank <= 1'b0;
		end
	end

	// Active-high level, one cycle behind its inputs
	always_ff @(posedge CLK) begin
		if (RESET) begin
			nmi <= 1'b0;
		end else begin
			nmi <= nmi_enable & vblank;
		end
	end

endmodule

/* src/ppu_data_port.sv */
/*
 * PPUDATA port
 * Turns data strobes into one-cycle VRAM requests and keeps the read buffer
 */

module ppu_data_port (
	input  logic                CLK,
	input  logic                RESET,
	input  logic                data_wr,
	input  logic                data_rd,
	input  logic [7:0]          wdata,
	input  ppu_pkg::vram_addr_u vram_addr,
	input  logic [7:0]          vram_rdata,
	output ppu_pkg::vram_req_t  vram,
	output logic [7:0]          read_buffer
);

	// Read issued last cycle, data arrives this cycle
	logic rd_pending;

	// ========================================================================
	// Request strobes
	// ========================================================================

	// Each strobe is high for the single cycle after the CPU access
	always_ff @(posedge CLK) begin
		if (RESET) begin
			vram.wr <= 1'b0;
			vram.rd <= 1'b0;
		end else begin
			vram.wr <= data_wr;
			vram.rd <= data_rd;
		end
	end

	// ========================================================================
	// Request payload
	// ========================================================================

	// Address is sampled before the scroll block steps it
	always_ff @(posedge CLK) begin
		if (data_wr || data_rd) begin
			vram.addr <= vram_addr.flat[13:0];
		end
		if (data_wr) begin
			vram.wdata <= wdata;
		end
	end

	// ========================================================================
	// Read buffer
	// ========================================================================

	always_ff @(posedge CLK) begin
		if (RESET) begin
			rd_pending <= 1'b0;
		end else begin
			rd_pending <= vram.rd;
		end
	end

	// Memory answers one cycle after rd
	// CPU sees this byte on its next PPUDATA read
	always_ff @(posedge CLK) begin
		if (RESET) begin
			read_buffer <= '0;
		end else if (rd_pending) begin
			read_buffer <= vram_rdata;
		end
	end

endmodule

/* src/ppu_scroll_addr.sv */
/*
 * PPU scroll and address registers
 * Shared write toggle, temporary (t) and current (v) VRAM address
 */

module ppu_scroll_addr (
	input  logic                CLK,
	input  logic                RESET,
	input  ppu_pkg::ppu_ctrl_t  ctrl,
	input  logic                ctrl_wr,
	input  logic                scroll_wr,
	input  logic                addr_wr,
	input  logic                data_wr,
	input  logic                data_rd,
	input  logic                status_rd,
	input  logic [7:0]          wdata,
	output ppu_pkg::vram_addr_u vram_addr
);

	// Write toggle shared by PPUSCROLL and PPUADDR
	logic toggle;
	// Temporary address, built up by register writes
	ppu_pkg::vram_addr_u temp_addr;
	// Address step picked by PPUCTRL bit 2
	logic [14:0] step;

	assign step = ctrl.increment ? ppu_pkg::INC_DOWN : ppu_pkg::INC_ACROSS;

	// ========================================================================
	// Write toggle
	// ========================================================================

	always_ff @(posedge CLK) begin
		if (RESET) begin
			toggle <= 1'b0;
		end else if (status_rd) begin
			// Status read rearms the first write
			toggle <= 1'b0;
		end else if (scroll_wr || addr_wr) begin
			toggle <= ~toggle;
		end
	end

	// ========================================================================
	// Temporary address
	// ========================================================================

	always_ff @(posedge CLK) begin
		if (RESET) begin
			temp_addr <= '0;
		end else if (ctrl_wr) begin
			// Base nametable select
			temp_addr.scroll.nametable <= wdata[1:0];
		end else if (scroll_wr) begin
			if (!toggle) begin
				// First write is X, fine X is not kept
				temp_addr.scroll.coarse_x <= wdata[7:3];
			end else begin
				// Second write is Y
				temp_addr.scroll.coarse_y <= wdata[7:3];
				temp_addr.scroll.fine_y   <= wdata[2:0];
			end
		end else if (addr_wr) begin
			if (!toggle) begin
				// High byte first, only 6 bits reach the address
				temp_addr.flat[13:8] <= wdata[5:0];
				temp_addr.flat[14]   <= 1'b0;
			end else begin
				temp_addr.flat[7:0] <= wdata;
			end
		end
	end

	// ========================================================================
	// Current address
	// ========================================================================

	always_ff @(posedge CLK) begin
		if (RESET) begin
			vram_addr <= '0;
		end else if (addr_wr && toggle) begin
			// Low byte completes the pair and is copied over with it
			vram_addr.flat <= {temp_addr.flat[14:8], wdata};
		end else if (data_wr || data_rd) begin
			// Step after every PPUDATA access, wraps in 15 bits
			vram_addr.flat <= vram_addr.flat + step;
		end
	end

endmodule

/* src/ppu_regs.sv */
/*
 * PPU register window
 * Decodes CPU strobes into per-register pulses, stores PPUCTRL, builds read data
 */

module ppu_regs (
	input  logic              CLK,
	input  logic              RESET,
	input  ppu_pkg::cpu_bus_t cpu,
	input  logic              vblank,
	input  logic [7:0]        read_buffer,
	output ppu_pkg::ppu_ctrl_t ctrl,
	output logic              ctrl_wr,
	output logic              scroll_wr,
	output logic              addr_wr,
	output logic              data_wr,
	output logic              data_rd,
	output logic              status_rd,
	output logic [7:0]        wdata,
	output logic [7:0]        cpu_rdata
);

	// ========================================================================
	// Strobe decode
	// ========================================================================

	// Pulses last exactly as long as the CPU strobe
	assign ctrl_wr   = cpu.wr && (cpu.addr == ppu_pkg::REG_CTRL);
	assign scroll_wr = cpu.wr && (cpu.addr == ppu_pkg::REG_SCROLL);
	assign addr_wr   = cpu.wr && (cpu.addr == ppu_pkg::REG_ADDR);
	assign data_wr   = cpu.wr && (cpu.addr == ppu_pkg::REG_DATA);
	assign data_rd   = cpu.rd && (cpu.addr == ppu_pkg::REG_DATA);
	assign status_rd = cpu.rd && (cpu.addr == ppu_pkg::REG_STATUS);

	// Data byte goes straight on to the address and data blocks
	assign wdata = cpu.wdata;

	// PPUCTRL keeps bits 7..2, the nametable bits live in the temp address
	always_ff @(posedge CLK) begin
		if (RESET) begin
			ctrl <= '0;
		end else if (ctrl_wr) begin
			ctrl <= ppu_pkg::ppu_ctrl_t'(cpu.wdata[7:2]);
		end
	end

	// ========================================================================
	// Read data
	// ========================================================================

	always_ff @(posedge CLK) begin
		if (RESET) begin
			cpu_rdata <= '0;
		end else if (cpu.rd) begin
			case (cpu.addr)
				// Write-only registers read back as zero
				ppu_pkg::REG_CTRL,
				ppu_pkg::REG_MASK: cpu_rdata <= '0;
				// Sprite 0 hit and overflow are not modelled
				// Low five bits are open bus and keep the last value
				ppu_pkg::REG_STATUS: cpu_rdata <= {vblank, 2'b00, cpu_rdata[4:0]};
				// Buffered read, returns the byte fetched by the previous access
				ppu_pkg::REG_DATA: cpu_rdata <= read_buffer;
				// OAM and the write-twice registers leave the bus alone
				ppu_pkg::REG_OAMADDR,
				ppu_pkg::REG_OAMDATA,
				ppu_pkg::REG_SCROLL,
				ppu_pkg::REG_ADDR: cpu_rdata <= cpu_rdata;
				default: cpu_rdata <= cpu_rdata;
			endcase
		end
	end

endmodule

/* src/ppu_pkg.sv */
/*
 * PPU shared definitions
 * Frame timing constants, CPU register offsets and the bus and register types
 */

package ppu_pkg;

	// ========================================================================
	// Frame geometry
	// ========================================================================

	// Counter widths, 341 dots and 262 lines both fit in 9 bits
	localparam int DOT_W  = 9;
	localparam int LINE_W = 9;

	localparam logic [DOT_W-1:0]  CYCLES_PER_LINE = 9'd341;
	localparam logic [LINE_W-1:0] LINES_PER_FRAME = 9'd262;

	// Vblank starts on line 241 and ends on the pre-render line
	localparam logic [LINE_W-1:0] VBLANK_LINE    = 9'd241;
	localparam logic [LINE_W-1:0] PRERENDER_LINE = 9'd261;
	// Flag changes as the counter leaves this dot
	localparam logic [DOT_W-1:0]  VBLANK_DOT     = 9'd1;

	// ========================================================================
	// CPU register window, mirrored every 8 bytes on the CPU side
	// ========================================================================

	localparam logic [2:0] REG_CTRL    = 3'd0;
	localparam logic [2:0] REG_MASK    = 3'd1;
	localparam logic [2:0] REG_STATUS  = 3'd2;
	localparam logic [2:0] REG_OAMADDR = 3'd3;
	localparam logic [2:0] REG_OAMDATA = 3'd4;
	localparam logic [2:0] REG_SCROLL  = 3'd5;
	localparam logic [2:0] REG_ADDR    = 3'd6;
	localparam logic [2:0] REG_DATA    = 3'd7;

	// VRAM address step after a PPUDATA access
	localparam logic [14:0] INC_ACROSS = 15'd1;
	localparam logic [14:0] INC_DOWN   = 15'd32;

	// One CPU access, wr and rd are never high together
	typedef struct packed {
		logic       wr;
		logic       rd;
		logic [2:0] addr;
		logic [7:0] wdata;
	} cpu_bus_t;

	// Upper six bits of PPUCTRL, same order as the register byte 7..2
	typedef struct packed {
		logic nmi_enable;
		// Master/slave select, stored but not used
		logic spare;
		logic sprite_size;
		logic bg_table;
		logic sprite_table;
		// 0 steps across (1), 1 steps down (32)
		logic increment;
	} ppu_ctrl_t;

	// Scroll layout of the 15-bit VRAM address register
	typedef struct packed {
		logic [2:0] fine_y;
		logic [1:0] nametable;
		logic [4:0] coarse_y;
		logic [4:0] coarse_x;
	} vram_scroll_t;

	// Same word seen as scroll fields or as a flat address
	typedef union packed {
		vram_scroll_t scroll;
		logic [14:0]  flat;
	} vram_addr_u;

	// Request on the external VRAM bus
	typedef struct packed {
		logic [13:0] addr;
		logic [7:0]  wdata;
		logic        wr;
		logic        rd;
	} vram_req_t;

endpackage
